// File: tests/grant_patterns.txt
// grant arbiter stimulus, one line per cycle after reset
// each word is 3 hex digits: request mask (2 digits) then hold length (1 digit)
// single strobe on line 0
011
001
001
// lines 2, 3 and 5 at once, hold 0
2C0
000
000
000
000
000
000
// hold 5, later hold changes ignored
805
005
00F
00F
00F
00F
00F
// hold 15 with requests arriving during the grant
40F
00F
500
010
010
090
000
000
000
000
000
000
000
000
000
000
000
// served in order, with a strobe on line 3 at its own take
002
000
000
081
000
001
000
000

// File: grant_arbiter.f
verilog/arb_pkg.sv
verilog/pry2oht.sv
verilog/pending_reg.sv
verilog/hold_timer.sv
verilog/grant_fsm.sv
verilog/grant_arbiter.sv
tests/grant_arbiter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the grant arbiter testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

MDIR=obj_dir
LOG=sim.log
TOP=grant_arbiter_tb

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$MDIR" \
    -f grant_arbiter.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$MDIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// File: tests/grant_arbiter_tb.sv
// testbench for the grant arbiter, pattern-driven stimulus checked against a cycle model
`timescale 1ns/1ps
`default_nettype none

module grant_arbiter_tb;

    localparam int PAT_LINES   = 42;  // data lines in the pattern file
    localparam int TAIL_LINES  = 80;  // idle drain plus random block
    localparam int RAND_FIRST  = 4;   // tail offset of the random block
    localparam int RAND_LEN    = 8;
    localparam int WATCHDOG_NS = (PAT_LINES + TAIL_LINES + 20) * 10;

    logic                           clk;
    logic                           rst_n;
    logic [arb_pkg::NUM_REQ-1:0]    req;
    logic [arb_pkg::HOLD_W-1:0]     hold;
    arb_pkg::grant_s                grant;
    logic [arb_pkg::NUM_REQ-1:0]    pending;

    logic [11:0]                    pat_mem [0:PAT_LINES-1];  // {req, hold}

    // reference model state
    logic [arb_pkg::NUM_REQ-1:0]    m_pend;
    logic                           m_busy;
    int                             m_remain;   // grant cycles still to come
    arb_pkg::grant_s                m_grant;
    int                             m_grants;

    int                             errors;
    int                             checks;
    int                             dut_grants;
    logic                           prev_active;
    logic [31:0]                    lcg_state;

    grant_arbiter i_dut
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .hold    (hold),
        .grant   (grant),
        .pending (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // scans downward so the last hit is the lowest set bit, -1 when empty
    function automatic int lowest_index(input logic [arb_pkg::NUM_REQ-1:0] v);
        int idx;
        idx = -1;
        for (int i = arb_pkg::NUM_REQ - 1; i >= 0; i--)
        begin
            if (v[i])
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // one rising edge of the reference model
    task automatic model_step(input logic [arb_pkg::NUM_REQ-1:0] r,
                              input logic [arb_pkg::HOLD_W-1:0]  h);
        int                          idx;
        logic [arb_pkg::NUM_REQ-1:0] pick;
        idx  = lowest_index(m_pend);
        pick = '0;
        if (!m_busy && idx >= 0)
        begin
            pick[idx]      = 1'b1;
            m_busy         = 1'b1;
            m_remain       = (h == '0) ? 1 : int'(h);  // zero length runs one cycle
            m_grant.active = 1'b1;
            m_grant.line   = pick;
            m_grant.id     = arb_pkg::ID_W'(idx);
            m_grants++;
        end
        else if (m_busy)
        begin
            m_remain--;
            if (m_remain == 0)
            begin
                m_busy  = 1'b0;
                m_grant = '0;
            end
        end
        m_pend = (m_pend & ~pick) | r;  // a strobe beats the clear
    endtask

    task automatic check_outputs();
        checks++;
        assert (grant == m_grant)
        else
        begin
            errors++;
            $display("Fail at %0d ns: grant expected %h, got %h", $time, m_grant, grant);
        end
        assert (pending == m_pend)
        else
        begin
            errors++;
            $display("Fail at %0d ns: pending expected %h, got %h", $time, m_pend, pending);
        end
        if (grant.active && !prev_active)
        begin
            dut_grants++;  // grants are always split by an idle cycle
        end
        prev_active = grant.active;
    endtask

    ////////////////////////////////////////
    // stimulus and checking
    ////////////////////////////////////////

    initial
    begin
        logic [11:0] word;
        rst_n       = 1'b0;
        req         = '0;
        hold        = '0;
        m_pend      = '0;
        m_busy      = 1'b0;
        m_remain    = 0;
        m_grant     = '0;
        m_grants    = 0;
        errors      = 0;
        checks      = 0;
        dut_grants  = 0;
        prev_active = 1'b0;
        lcg_state   = 32'd98;
        $readmemh("tests/grant_patterns.txt", pat_mem);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_outputs();  // reset values

        for (int c = 0; c < PAT_LINES + TAIL_LINES; c++)
        begin
            if (c < PAT_LINES)
            begin
                word = pat_mem[c];
            end
            else if (c - PAT_LINES >= RAND_FIRST && c - PAT_LINES < RAND_FIRST + RAND_LEN)
            begin
                lcg_state = lcg_next(lcg_state);
                word      = {lcg_state[23:16], 2'b00, lcg_state[9:8]};  // short holds
            end
            else
            begin
                word = 12'h001;  // idle, hold 1
            end
            req  = word[11:4];
            hold = word[3:0];
            @(posedge clk);
            model_step(req, hold);
            @(negedge clk);
            check_outputs();
        end

        // everything requested has been served
        assert (dut_grants == m_grants)
        else
        begin
            errors++;
            $display("Fail at %0d ns: grant count expected %0d, got %0d",
                     $time, m_grants, dut_grants);
        end
        assert (pending == '0 && !grant.active)
        else
        begin
            errors++;
            $display("traffic did not drain, pending %h still set at the end", pending);
        end

        $display("errors: %0d, checks: %0d, grants: %0d", errors, checks, dut_grants);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    ////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////

    initial
    begin
        #(WATCHDOG_NS);
        $display("simulation timed out after %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule: grant_arbiter_tb

`default_nettype wire

// File: verilog/grant_arbiter.sv
// eight-line request arbiter with lowest-index priority and timed grants
`timescale 1ns/1ps
`default_nettype none

module grant_arbiter
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [arb_pkg::NUM_REQ-1:0] req,      // request strobes
    input  logic [arb_pkg::HOLD_W-1:0]  hold,     // grant length, level
    output arb_pkg::grant_s             grant,
    output logic [arb_pkg::NUM_REQ-1:0] pending
);

    logic [arb_pkg::NUM_REQ-1:0] pend_bits;
    logic [arb_pkg::NUM_REQ-1:0] pick_oht;
    logic                        pick_vld;
    logic                        take;
    logic [arb_pkg::NUM_REQ-1:0] take_oht;
    logic                        start;
    logic                        last;
    arb_pkg::grant_s             grant_q;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    pending_reg i_pending
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .take      (take),
        .take_oht  (take_oht),
        .pend_bits (pend_bits)
    );

    // lowest index wins
    pry2oht i_pick
    (
        .pry (pend_bits),
        .oht (pick_oht),
        .vld (pick_vld)
    );

    hold_timer i_timer
    (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .hold  (hold),
        .last  (last)
    );

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    grant_fsm i_fsm
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .pick_oht (pick_oht),
        .pick_vld (pick_vld),
        .last     (last),
        .take     (take),
        .take_oht (take_oht),
        .start    (start),
        .grant_q  (grant_q)
    );

    assign grant   = grant_q;
    assign pending = pend_bits;

endmodule: grant_arbiter

`default_nettype wire

// File: verilog/grant_fsm.sv
// idle/busy arbiter state machine, latches the picked line and drives the grant
`timescale 1ns/1ps
`default_nettype none

module grant_fsm
(
    input  logic                        clk,
    input  logic                        rst_n,
    // from the priority picker
    input  logic [arb_pkg::NUM_REQ-1:0] pick_oht,
    input  logic                        pick_vld,
    // from the timer
    input  logic                        last,
    // to the pending register
    output logic                        take,
    output logic [arb_pkg::NUM_REQ-1:0] take_oht,
    // to the timer
    output logic                        start,
    // current grant
    output arb_pkg::grant_s             grant_q
);

    arb_pkg::arb_state_e     state_q;
    arb_pkg::arb_state_e     state_d;
    arb_pkg::grant_s         grant_d;
    logic [arb_pkg::ID_W-1:0] pick_id;

    ////////////////////////////////////////
    // one-hot to binary
    ////////////////////////////////////////

    // pick_oht has at most one bit set, so OR-ing indices is enough
    always_comb
    begin
        pick_id = '0;
        for (int i = 0; i < arb_pkg::NUM_REQ; i++)
        begin
            if (pick_oht[i])
            begin
                pick_id = pick_id | arb_pkg::ID_W'(i);
            end
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    assign take     = (state_q == arb_pkg::ST_IDLE) && pick_vld;
    assign take_oht = pick_oht;
    assign start    = take;  // timer loads on the same edge as the grant

    always_comb
    begin
        state_d = state_q;
        grant_d = grant_q;
        case (state_q)
            arb_pkg::ST_IDLE:
            begin
                if (pick_vld)
                begin
                    state_d        = arb_pkg::ST_BUSY;
                    grant_d.active = 1'b1;
                    grant_d.line   = pick_oht;
                    grant_d.id     = pick_id;
                end
            end
            arb_pkg::ST_BUSY:
            begin
                if (last)
                begin
                    state_d = arb_pkg::ST_IDLE;
                    grant_d = '0;  // leaves one idle cycle before the next pick
                end
            end
            default:
            begin
                state_d = arb_pkg::ST_IDLE;
                grant_d = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= arb_pkg::ST_IDLE;
            grant_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            grant_q <= grant_d;
        end
    end

endmodule: grant_fsm

`default_nettype wire

// File: verilog/hold_timer.sv
// grant length timer, counts down max(hold,1) cycles and flags the final one
`timescale 1ns/1ps
`default_nettype none

module hold_timer
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,  // grant begins at this edge
    input  logic [arb_pkg::HOLD_W-1:0] hold,   // sampled on start only
    output logic                       last    // final cycle of the grant
);

    logic [arb_pkg::HOLD_W-1:0] cnt;      // cycles left after this one
    logic                       running;
    logic [arb_pkg::HOLD_W-1:0] load_val;

    // zero length means one cycle
    assign load_val = (hold == '0) ? '0 : hold - 1'b1;

    ////////////////////////////////////////
    // counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt     <= '0;
            running <= 1'b0;
        end
        else if (start)
        begin
            cnt     <= load_val;
            running <= 1'b1;
        end
        else if (last)
        begin
            running <= 1'b0;  // stop by itself
        end
        else if (running)
        begin
            cnt <= cnt - 1'b1;
        end
    end

    assign last = running && (cnt == '0);

endmodule: hold_timer

`default_nettype wire

// File: verilog/pending_reg.sv
// pending request register, set by request strobes and cleared by a granted line
`timescale 1ns/1ps
`default_nettype none

module pending_reg
(
    input  logic                        clk,
    input  logic                        rst_n,
    // requesters
    input  logic [arb_pkg::NUM_REQ-1:0] req,        // single-cycle strobes
    // from the state machine
    input  logic                        take,       // a line is granted this cycle
    input  logic [arb_pkg::NUM_REQ-1:0] take_oht,   // which line
    // pending state
    output logic [arb_pkg::NUM_REQ-1:0] pend_bits
);

    logic [arb_pkg::NUM_REQ-1:0] clr_mask;
    logic [arb_pkg::NUM_REQ-1:0] pend_d;

    ////////////////////////////////////////
    // next value
    ////////////////////////////////////////

    always_comb
    begin
        clr_mask = take ? take_oht : '0;
        // clear first, then set, so a new strobe on the taken line survives
        pend_d   = (pend_bits & ~clr_mask) | req;
    end

    ////////////////////////////////////////
    // register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_bits <= '0;
        end
        else
        begin
            pend_bits <= pend_d;  // repeated strobes merge here
        end
    end

endmodule: pending_reg

`default_nettype wire

// File: verilog/pry2oht.sv
// rightmost priority to one-hot conversion, with a valid flag when any bit is set
`timescale 1ns/1ps
`default_nettype none

module pry2oht
(
    input  logic [arb_pkg::NUM_REQ-1:0] pry,  // priority
    output logic [arb_pkg::NUM_REQ-1:0] oht,  // one-hot
    output logic                        vld   // valid
);

    ////////////////////////////////////////
    // loop form
    ////////////////////////////////////////

    // vld doubles as the "already found" flag while walking up from bit 0,
    // so every bit above the first set one is masked off
    always_comb
    begin: loop
        vld = 1'b0;
        for (int i = 0; i < arb_pkg::NUM_REQ; i++)
        begin
            oht[i] = pry[i] & ~vld;  // only the first hit passes
            vld    = pry[i] |  vld;
        end
    end: loop

endmodule: pry2oht

`default_nettype wire

// File: verilog/arb_pkg.sv
// arbiter package: line counts, field widths, state encoding and grant descriptor
`default_nettype none

package arb_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int unsigned NUM_REQ = 8;  // request lines
    localparam int unsigned ID_W    = 3;  // binary line index
    localparam int unsigned HOLD_W  = 4;  // grant length in cycles

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    typedef enum logic
    {
        ST_IDLE = 1'b0,  // waiting for a pending line
        ST_BUSY = 1'b1   // grant held, timer running
    } arb_state_e;

    ////////////////////////////////////////
    // grant descriptor
    ////////////////////////////////////////

    // 12 bits, active on top
    typedef struct packed
    {
        logic               active;  // a line is being served
        logic [NUM_REQ-1:0] line;    // one-hot
        logic [ID_W-1:0]    id;      // index of the set bit in line
    } grant_s;

endpackage: arb_pkg

`default_nettype wire
